// ==== fedp_apb_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module fedp_apb_regs import fedp_pkg::*; (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    psel,
    input  wire                    penable,
    input  wire                    pwrite,
    input  wire [7:0]              paddr,
    input  wire [FEDP_DATA_W-1:0]  pwdata,
    output logic [FEDP_DATA_W-1:0] prdata,
    output logic                   pready,
    output logic                   pslverr,
    output logic                   req_valid,
    output fedp_req_t              req,
    input  wire                    res_valid,
    input  wire [FEDP_DATA_W-1:0]  res
);

    logic [FEDP_DATA_W-1:0]   a_r;
    logic [FEDP_DATA_W-1:0]   b_r;
    logic [FEDP_DATA_W-1:0]   c_r;
    logic [FEDP_DATA_W-1:0]   d_r;
    fedp_fmt_e                fmt_r;
    logic                     sat_r;
    logic [FEDP_DONE_W-1:0]   done_count;
    logic [FEDP_FLIGHT_W-1:0] in_flight;

    logic                     access;
    logic                     addr_ok;
    logic                     read_only;
    logic                     wr_en;
    logic [FEDP_DATA_W-1:0]   rd_data;

    // ========================================
    // Address decode
    // ========================================

    assign access = psel & penable;

    always_comb begin
        addr_ok   = 1'b1;
        read_only = 1'b0;
        rd_data   = '0;
        case (paddr)
            REG_CTRL:   rd_data = FEDP_DATA_W'({sat_r, fmt_r});
            REG_A:      rd_data = a_r;
            REG_B:      rd_data = b_r;
            REG_C:      rd_data = c_r;
            REG_D: begin
                rd_data   = d_r;
                read_only = 1'b1;
            end
            REG_STATUS: begin
                rd_data   = {{(FEDP_DATA_W-FEDP_FLIGHT_W-FEDP_DONE_W){1'b0}},
                             in_flight, done_count};
                read_only = 1'b1;
            end
            default:    addr_ok = 1'b0;
        endcase
    end

    // Zero wait states on every transfer
    assign pready  = 1'b1;
    assign pslverr = access & (~addr_ok | (pwrite & read_only));
    assign prdata  = (access & ~pwrite) ? rd_data : '0;
    assign wr_en   = access & pwrite & ~pslverr;

    // Start pulse, fmt and sat come straight from the write data
    assign req_valid = wr_en & (paddr == REG_CTRL) & pwdata[CTRL_START_BIT];

    always_comb begin
        req.fmt = fedp_fmt_e'(pwdata[FEDP_FMT_W-1:0]);
        req.sat = pwdata[CTRL_SAT_BIT];
        req.a   = a_r;
        req.b   = b_r;
        req.c   = c_r;
    end

    // ========================================
    // Register state
    // ========================================

    always_ff @(posedge clk) begin
        if (reset) begin
            a_r        <= '0;
            b_r        <= '0;
            c_r        <= '0;
            d_r        <= '0;
            fmt_r      <= FMT_S8;
            sat_r      <= 1'b0;
            done_count <= '0;
            in_flight  <= '0;
        end else begin
            if (wr_en) begin
                case (paddr)
                    REG_CTRL: begin
                        fmt_r <= fedp_fmt_e'(pwdata[FEDP_FMT_W-1:0]);
                        sat_r <= pwdata[CTRL_SAT_BIT];
                    end
                    REG_A:   a_r <= pwdata;
                    REG_B:   b_r <= pwdata;
                    REG_C:   c_r <= pwdata;
                    default: ;
                endcase
            end
            if (res_valid) begin
                d_r        <= res;
                done_count <= done_count + 1'b1;
            end
            // Start and completion may land on the same edge
            in_flight <= in_flight + FEDP_FLIGHT_W'(req_valid)
                                   - FEDP_FLIGHT_W'(res_valid);
        end
    end

endmodule

`default_nettype wire

// ==== fedp_clk_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module fedp_clk_gen (
    output logic clk,
    output logic reset
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Reset held over the first 4 rising edges
    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

`default_nettype wire

// ==== fedp_finish.sv ====
`timescale 1ns/100ps
`default_nettype none

module fedp_finish import fedp_pkg::*; (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    in_valid,
    input  fedp_sum_t              sum,
    output logic                   out_valid,
    output logic [FEDP_DATA_W-1:0] res
);

    fedp_acc_t                    acc_next;
    fedp_acc_t                    acc_r;
    logic                         acc_valid;
    logic signed [FEDP_ACC_W-1:0] acc_s;
    logic [FEDP_DATA_W-1:0]       res_next;

    // ========================================
    // Stage 3, add C
    // ========================================

    always_comb begin
        acc_next.acc = FEDP_ACC_W'($signed(sum.sum)) + FEDP_ACC_W'($signed(sum.c));
        acc_next.sat = sum.sat;
    end

    // ========================================
    // Stage 4, clamp or wrap
    // ========================================

    assign acc_s = $signed(acc_r.acc);

    always_comb begin
        res_next = acc_r.acc[FEDP_DATA_W-1:0];
        if (acc_r.sat) begin
            if (acc_s > FEDP_ACC_MAX) begin
                res_next = FEDP_ACC_MAX[FEDP_DATA_W-1:0];
            end else if (acc_s < FEDP_ACC_MIN) begin
                res_next = FEDP_ACC_MIN[FEDP_DATA_W-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            acc_valid <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            acc_valid <= in_valid;
            out_valid <= acc_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            acc_r <= acc_next;
        end
        if (acc_valid) begin
            res <= res_next;
        end
    end

endmodule

`default_nettype wire

// ==== fedp_mul.sv ====
`timescale 1ns/100ps
`default_nettype none

module fedp_mul import fedp_pkg::*; (
    input  wire       clk,
    input  wire       reset,
    input  wire       in_valid,
    input  fedp_req_t req,
    output logic      out_valid,
    output fedp_prod_t prod
);

    logic signed [FEDP_LANE_W-1:0]   a_lane    [FEDP_LANES];
    logic signed [FEDP_LANE_W-1:0]   b_lane    [FEDP_LANES];
    logic signed [2*FEDP_LANE_W-1:0] prod_full [FEDP_LANES];
    fedp_prod_t                      prod_next;

    // Lane unpack, lanes a format does not use stay zero
    always_comb begin
        for (int i = 0; i < FEDP_LANES; i++) begin
            a_lane[i] = '0;
            b_lane[i] = '0;
        end
        case (req.fmt)
            FMT_S8: begin
                for (int i = 0; i < 4; i++) begin
                    a_lane[i] = {req.a[8*i+7], req.a[8*i +: 8]};
                    b_lane[i] = {req.b[8*i+7], req.b[8*i +: 8]};
                end
            end
            FMT_U8: begin
                for (int i = 0; i < 4; i++) begin
                    a_lane[i] = {1'b0, req.a[8*i +: 8]};
                    b_lane[i] = {1'b0, req.b[8*i +: 8]};
                end
            end
            FMT_S4: begin
                for (int i = 0; i < FEDP_LANES; i++) begin
                    a_lane[i] = {{(FEDP_LANE_W-4){req.a[4*i+3]}}, req.a[4*i +: 4]};
                    b_lane[i] = {{(FEDP_LANE_W-4){req.b[4*i+3]}}, req.b[4*i +: 4]};
                end
            end
            default: ;
        endcase
    end

    // Full-width products, every result fits in FEDP_PROD_W
    always_comb begin
        for (int i = 0; i < FEDP_LANES; i++) begin
            prod_full[i]            = a_lane[i] * b_lane[i];
            prod_next.products[i]   = prod_full[i][FEDP_PROD_W-1:0];
        end
        prod_next.c   = req.c;
        prod_next.sat = req.sat;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            prod <= prod_next;
        end
    end

endmodule

`default_nettype wire

// ==== fedp_pipe.sv ====
`timescale 1ns/100ps
`default_nettype none

module fedp_pipe import fedp_pkg::*; (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    req_valid,
    input  fedp_req_t              req,
    output logic                   res_valid,
    output logic [FEDP_DATA_W-1:0] res
);

    // Stage boundaries
    logic       s1_valid;
    fedp_prod_t s1_prod;
    logic       s2_valid;
    fedp_sum_t  s2_sum;

    // Edge 1, lane products
    fedp_mul u_mul (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (req_valid),
        .req       (req),
        .out_valid (s1_valid),
        .prod      (s1_prod)
    );

    // Edge 2, product sum
    fedp_reduce u_reduce (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (s1_valid),
        .prod      (s1_prod),
        .out_valid (s2_valid),
        .sum       (s2_sum)
    );

    // Edges 3 and 4, accumulate then clamp or wrap
    fedp_finish u_finish (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (s2_valid),
        .sum       (s2_sum),
        .out_valid (res_valid),
        .res       (res)
    );

endmodule

`default_nettype wire

// ==== fedp_pkg.sv ====
`default_nettype none

package fedp_pkg;

    // ========================================
    // Sizes
    // ========================================

    localparam int FEDP_DATA_W   = 32;
    localparam int FEDP_FMT_W    = 2;
    localparam int FEDP_LANES    = 8;
    // Lane operand after sign or zero extension
    localparam int FEDP_LANE_W   = 9;
    localparam int FEDP_PROD_W   = 17;
    localparam int FEDP_SUM_W    = 20;
    localparam int FEDP_ACC_W    = 34;
    localparam int FEDP_DONE_W   = 16;
    localparam int FEDP_FLIGHT_W = 4;

    // CTRL bit positions, fmt sits in the low bits
    localparam int CTRL_SAT_BIT   = 2;
    localparam int CTRL_START_BIT = 8;

    // Signed 32-bit clamp limits at accumulator width
    localparam logic signed [FEDP_ACC_W-1:0] FEDP_ACC_MAX =
        {{(FEDP_ACC_W-31){1'b0}}, {31{1'b1}}};
    localparam logic signed [FEDP_ACC_W-1:0] FEDP_ACC_MIN =
        {{(FEDP_ACC_W-31){1'b1}}, {31{1'b0}}};

    // ========================================
    // Encodings
    // ========================================

    typedef enum logic [FEDP_FMT_W-1:0] {
        FMT_S8 = 2'd0,
        FMT_U8 = 2'd1,
        FMT_S4 = 2'd2
    } fedp_fmt_e;

    typedef enum logic [7:0] {
        REG_CTRL   = 8'h00,
        REG_A      = 8'h04,
        REG_B      = 8'h08,
        REG_C      = 8'h0C,
        REG_D      = 8'h10,
        REG_STATUS = 8'h14
    } fedp_reg_e;

    // ========================================
    // Stage payloads
    // ========================================

    typedef struct packed {
        fedp_fmt_e              fmt;
        logic                   sat;
        logic [FEDP_DATA_W-1:0] a;
        logic [FEDP_DATA_W-1:0] b;
        logic [FEDP_DATA_W-1:0] c;
    } fedp_req_t;

    typedef struct packed {
        logic [FEDP_LANES-1:0][FEDP_PROD_W-1:0] products;
        logic [FEDP_DATA_W-1:0]                 c;
        logic                                   sat;
    } fedp_prod_t;

    typedef struct packed {
        logic [FEDP_SUM_W-1:0]  sum;
        logic [FEDP_DATA_W-1:0] c;
        logic                   sat;
    } fedp_sum_t;

    typedef struct packed {
        logic [FEDP_ACC_W-1:0] acc;
        logic                  sat;
    } fedp_acc_t;

endpackage

`default_nettype wire

// ==== fedp_reduce.sv ====
`timescale 1ns/100ps
`default_nettype none

module fedp_reduce import fedp_pkg::*; (
    input  wire        clk,
    input  wire        reset,
    input  wire        in_valid,
    input  fedp_prod_t prod,
    output logic       out_valid,
    output fedp_sum_t  sum
);

    logic signed [FEDP_SUM_W-1:0] lvl0 [FEDP_LANES];
    logic signed [FEDP_SUM_W-1:0] lvl1 [FEDP_LANES/2];
    logic signed [FEDP_SUM_W-1:0] lvl2 [FEDP_LANES/4];
    fedp_sum_t                    sum_next;

    // Balanced tree, 8 to 4 to 2 to 1
    always_comb begin
        for (int i = 0; i < FEDP_LANES; i++) begin
            lvl0[i] = FEDP_SUM_W'($signed(prod.products[i]));
        end
        for (int i = 0; i < FEDP_LANES/2; i++) begin
            lvl1[i] = lvl0[2*i] + lvl0[2*i+1];
        end
        for (int i = 0; i < FEDP_LANES/4; i++) begin
            lvl2[i] = lvl1[2*i] + lvl1[2*i+1];
        end
        sum_next.sum = lvl2[0] + lvl2[1];
        sum_next.c   = prod.c;
        sum_next.sat = prod.sat;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            sum <= sum_next;
        end
    end

endmodule

`default_nettype wire

// ==== fedp_top.f ====
fedp_pkg.sv
fedp_apb_regs.sv
fedp_mul.sv
fedp_reduce.sv
fedp_finish.sv
fedp_pipe.sv
fedp_top.sv
fedp_clk_gen.sv
tb_fedp_top.sv

// ==== fedp_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module fedp_top import fedp_pkg::*; (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    psel,
    input  wire                    penable,
    input  wire                    pwrite,
    input  wire [7:0]              paddr,
    input  wire [FEDP_DATA_W-1:0]  pwdata,
    output logic [FEDP_DATA_W-1:0] prdata,
    output logic                   pready,
    output logic                   pslverr
);

    logic                   req_valid;
    fedp_req_t              req;
    logic                   res_valid;
    logic [FEDP_DATA_W-1:0] res;

    fedp_apb_regs u_regs (
        .clk       (clk),
        .reset     (reset),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .req_valid (req_valid),
        .req       (req),
        .res_valid (res_valid),
        .res       (res)
    );

    fedp_pipe u_pipe (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req       (req),
        .res_valid (res_valid),
        .res       (res)
    );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the fedp testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --top-module tb_fedp_top -f fedp_top.f -o sim_fedp

# The simulator status is masked by tee, the log decides
./obj_dir/sim_fedp | tee sim.log

grep -q "STATUS: PASS" sim.log

// ==== tb_fedp_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_fedp_top import fedp_pkg::*; ();

    localparam int N_RAND          = 20;
    localparam int N_TESTS         = 3*N_RAND + 16;
    localparam int CYCLES_PER_TEST = 20;
    localparam int CLK_NS          = 4;
    localparam int TIMEOUT_NS      = N_TESTS*CYCLES_PER_TEST*CLK_NS + 2000;

    wire                    clk;
    wire                    reset;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [7:0]             paddr;
    logic [FEDP_DATA_W-1:0] pwdata;
    wire  [FEDP_DATA_W-1:0] prdata;
    wire                    pready;
    wire                    pslverr;

    logic [FEDP_DATA_W-1:0] exp_q [$];
    logic [FEDP_DATA_W-1:0] got_q [$];
    int                     n_pushed;
    int                     n_compared;
    int                     n_started;

    fedp_reg_e all_regs [6] = '{REG_CTRL, REG_A, REG_B, REG_C, REG_D, REG_STATUS};
    fedp_fmt_e all_fmts [3] = '{FMT_S8, FMT_U8, FMT_S4};

    fedp_clk_gen u_clk_gen (
        .clk   (clk),
        .reset (reset)
    );

    fedp_top DUT (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    // ========================================
    // Reference model and checks
    // ========================================

    function automatic logic [FEDP_DATA_W-1:0] fedp_model(input fedp_req_t r);
        longint acc;
        longint pa;
        longint pb;
        acc = longint'(r.c);
        if (r.c[31]) begin
            acc = acc - 64'sh1_0000_0000;
        end
        for (int i = 0; i < 8; i++) begin
            pa = 64'sd0;
            pb = 64'sd0;
            if (r.fmt == FMT_S4) begin
                pa = longint'(r.a[4*i +: 4]);
                pb = longint'(r.b[4*i +: 4]);
                if (pa > 64'sd7) pa = pa - 64'sd16;
                if (pb > 64'sd7) pb = pb - 64'sd16;
            end else if (i < 4) begin
                pa = longint'(r.a[8*i +: 8]);
                pb = longint'(r.b[8*i +: 8]);
                // Byte lanes are two's complement only in S8
                if (r.fmt == FMT_S8 && pa > 64'sd127) pa = pa - 64'sd256;
                if (r.fmt == FMT_S8 && pb > 64'sd127) pb = pb - 64'sd256;
            end
            acc = acc + pa*pb;
        end
        if (r.sat) begin
            if (acc > 64'sd2147483647) begin
                acc = 64'sd2147483647;
            end else if (acc < -64'sd2147483648) begin
                acc = -64'sd2147483648;
            end
        end
        return acc[31:0];
    endfunction

    function automatic fedp_req_t make_req(input fedp_fmt_e fmt, input logic sat,
                                           input logic [FEDP_DATA_W-1:0] a,
                                           input logic [FEDP_DATA_W-1:0] b,
                                           input logic [FEDP_DATA_W-1:0] c);
        fedp_req_t r;
        r.fmt = fmt;
        r.sat = sat;
        r.a   = a;
        r.b   = b;
        r.c   = c;
        return r;
    endfunction

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_result(input logic [FEDP_DATA_W-1:0] got,
                                input logic [FEDP_DATA_W-1:0] expected);
        if (got !== expected) begin
            report_error($sformatf("FAIL D got 0x%08h expected 0x%08h", got, expected));
        end
    endtask

    task automatic check_status(input logic [FEDP_DONE_W-1:0] got_done,
                                input logic [FEDP_DONE_W-1:0] exp_done,
                                input logic [FEDP_FLIGHT_W-1:0] got_flight,
                                input logic [FEDP_FLIGHT_W-1:0] exp_flight);
        if (got_done !== exp_done || got_flight !== exp_flight) begin
            report_error($sformatf("FAIL done_count got 0x%04h expected 0x%04h, %s 0x%0h 0x%0h",
                                   got_done, exp_done, "in_flight got/expected",
                                   got_flight, exp_flight));
        end
    endtask

    task automatic check_slverr(input logic [7:0] addr, input logic got, input logic expected);
        if (got !== expected) begin
            report_error($sformatf("FAIL pslverr at 0x%02h got 0x%0h expected 0x%0h",
                                   addr, got, expected));
        end
    endtask

    task automatic check_ready(input logic got);
        if (got !== 1'b1) begin
            report_error($sformatf("FAIL pready got 0x%0h expected 0x1", got));
        end
    endtask

    task automatic check_reg(input string name, input logic [FEDP_DATA_W-1:0] got,
                             input logic [FEDP_DATA_W-1:0] expected);
        if (got !== expected) begin
            report_error($sformatf("FAIL %s got 0x%08h expected 0x%08h", name, got, expected));
        end
    endtask

    // Results reach the compare process through queues
    always @(negedge clk) begin : compare
        logic [FEDP_DATA_W-1:0] got;
        logic [FEDP_DATA_W-1:0] exp_d;
        if (got_q.size() > 0 && exp_q.size() > 0) begin
            got   = got_q.pop_front();
            exp_d = exp_q.pop_front();
            check_result(got, exp_d);
            n_compared++;
        end
    end

    // ========================================
    // APB tasks
    // ========================================

    task automatic apb_write(input logic [7:0] addr, input logic [FEDP_DATA_W-1:0] data,
                             input logic exp_err);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        check_ready(pready);
        check_slverr(addr, pslverr, exp_err);
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, input logic exp_err,
                            output logic [FEDP_DATA_W-1:0] data);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        check_ready(pready);
        check_slverr(addr, pslverr, exp_err);
        data = prdata;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic read_status(output logic [FEDP_DONE_W-1:0] done,
                               output logic [FEDP_FLIGHT_W-1:0] flight);
        logic [FEDP_DATA_W-1:0] data;
        apb_read(REG_STATUS, 1'b0, data);
        done   = data[15:0];
        flight = data[19:16];
    endtask

    // Poll until done_count moves past the previous item, the watchdog bounds the loop
    task automatic wait_done(input int target, output logic [FEDP_DONE_W-1:0] done,
                             output logic [FEDP_FLIGHT_W-1:0] flight);
        read_status(done, flight);
        while (done == FEDP_DONE_W'(target - 1)) begin
            read_status(done, flight);
        end
    endtask

    task automatic start_item(input fedp_fmt_e fmt, input logic sat);
        apb_write(REG_CTRL, {23'd0, 1'b1, 5'd0, sat, fmt}, 1'b0);
        n_started++;
    endtask

    task automatic push_result(input logic [FEDP_DATA_W-1:0] got,
                               input logic [FEDP_DATA_W-1:0] expected);
        got_q.push_back(got);
        exp_q.push_back(expected);
        n_pushed++;
    endtask

    task automatic run_item(input fedp_req_t r, input logic [FEDP_DATA_W-1:0] expected);
        logic [FEDP_DATA_W-1:0]   d;
        logic [FEDP_DONE_W-1:0]   done;
        logic [FEDP_FLIGHT_W-1:0] flight;
        apb_write(REG_A, r.a, 1'b0);
        apb_write(REG_B, r.b, 1'b0);
        apb_write(REG_C, r.c, 1'b0);
        start_item(r.fmt, r.sat);
        wait_done(n_started, done, flight);
        check_status(done, FEDP_DONE_W'(n_started), flight, 4'd0);
        apb_read(REG_D, 1'b0, d);
        push_result(d, expected);
    endtask

    // ========================================
    // Stimulus
    // ========================================

    initial begin : stimulus
        fedp_req_t                r;
        fedp_req_t                r2;
        logic [FEDP_DATA_W-1:0]   d;
        logic [FEDP_DATA_W-1:0]   snap [6];
        logic [FEDP_DONE_W-1:0]   done0;
        logic [FEDP_DONE_W-1:0]   done;
        logic [FEDP_FLIGHT_W-1:0] flight;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        n_pushed   = 0;
        n_compared = 0;
        n_started  = 0;
        void'($urandom(32'h2a62b6d6));
        @(negedge reset);

        // Everything reads zero after reset
        foreach (all_regs[i]) begin
            apb_read(all_regs[i], 1'b0, d);
            check_reg(all_regs[i].name(), d, '0);
        end

        // Random items per format, wrap mode
        foreach (all_fmts[f]) begin
            for (int i = 0; i < N_RAND; i++) begin
                r = make_req(all_fmts[f], 1'b0, $urandom(), $urandom(), $urandom());
                run_item(r, fedp_model(r));
            end
        end

        // Wraparound past both limits
        run_item(make_req(FMT_U8, 1'b0, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h7FFF_FF00),
                 32'h8003_F704);
        run_item(make_req(FMT_S8, 1'b0, 32'h7F7F_7F7F, 32'h8080_8080, 32'h8000_0010),
                 32'h7FFF_0210);

        // Saturation at each limit, and one case inside range
        run_item(make_req(FMT_U8, 1'b1, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h7FFF_FF00),
                 32'h7FFF_FFFF);
        run_item(make_req(FMT_S8, 1'b1, 32'h7F7F_7F7F, 32'h8080_8080, 32'h8000_0010),
                 32'h8000_0000);
        run_item(make_req(FMT_S4, 1'b1, 32'h7777_7777, 32'h8888_8888, 32'h8000_0000),
                 32'h8000_0000);
        run_item(make_req(FMT_S4, 1'b1, 32'h8888_8888, 32'h8888_8888, 32'h7FFF_FF00),
                 32'h7FFF_FFFF);
        run_item(make_req(FMT_S8, 1'b1, 32'h0102_0304, 32'h0101_0101, 32'h0000_0005),
                 32'h0000_000F);

        // Two items in flight, operands change between the starts
        read_status(done0, flight);
        r  = make_req(FMT_S8, 1'b0, $urandom(), $urandom(), $urandom());
        r2 = make_req(FMT_U8, 1'b0, $urandom(), r.b, $urandom());
        apb_write(REG_A, r.a, 1'b0);
        apb_write(REG_B, r.b, 1'b0);
        apb_write(REG_C, r.c, 1'b0);
        start_item(r.fmt, r.sat);
        apb_write(REG_A, r2.a, 1'b0);
        apb_write(REG_C, r2.c, 1'b0);
        start_item(r2.fmt, r2.sat);
        // D already holds the first result, the second is still in the pipe
        apb_read(REG_D, 1'b0, d);
        push_result(d, fedp_model(r));
        wait_done(n_started, done, flight);
        apb_read(REG_D, 1'b0, d);
        push_result(d, fedp_model(r2));
        read_status(done, flight);
        check_status(done, done0 + 16'd2, flight, 4'd0);

        // Bus errors leave every register as it was
        foreach (all_regs[i]) begin
            apb_read(all_regs[i], 1'b0, snap[i]);
        end
        // Operands and CTRL read back as last written, start reads as zero
        check_reg("REG_CTRL", snap[0], {29'd0, r2.sat, r2.fmt});
        check_reg("REG_A", snap[1], r2.a);
        check_reg("REG_B", snap[2], r2.b);
        check_reg("REG_C", snap[3], r2.c);
        apb_read(8'h18, 1'b1, d);
        apb_read(8'h02, 1'b1, d);
        apb_write(8'h1C, 32'h1234_5678, 1'b1);
        apb_write(8'h40, 32'h0000_0100, 1'b1);
        apb_write(REG_D, 32'hDEAD_BEEF, 1'b1);
        apb_write(REG_STATUS, 32'hFFFF_FFFF, 1'b1);
        foreach (all_regs[i]) begin
            apb_read(all_regs[i], 1'b0, d);
            check_reg(all_regs[i].name(), d, snap[i]);
        end

        repeat (4) @(posedge clk);
        if (n_compared == n_pushed && got_q.size() == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            report_error("Some results never reached the compare process");
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        report_error("Timeout, the tests did not finish in the expected time");
    end

endmodule

`default_nettype wire
